/* common/mmu_pkg.sv */
`default_nettype none

package mmu_pkg;

    typedef logic [31:0] vaddr_t;
    typedef logic [31:0] paddr_t;
    typedef logic [18:0] vpn2_t;
    typedef logic [7:0]  asid_t;
    typedef logic [19:0] pfn_t;
    typedef logic [2:0]  cattr_t;

    // wide enough for up to 256 entries
    typedef logic [7:0]  tlb_idx_t;

    // vpn2 [31:13], asid [7:0], the rest reads zero
    typedef logic [31:0] entry_hi_t;
    // pfn [25:6], c [5:3], d, v, g
    typedef logic [25:0] entry_lo_t;

    localparam cattr_t CACHE_CACHEABLE = 3'd3;

    typedef struct packed {
        vpn2_t  vpn2;
        asid_t  asid;
        logic   g;
        pfn_t   pfn0;
        cattr_t c0;
        logic   d0;
        logic   v0;
        pfn_t   pfn1;
        cattr_t c1;
        logic   d1;
        logic   v1;
    } tlb_entry_t;

    typedef struct packed {
        logic     found;
        tlb_idx_t index;
        pfn_t     pfn;
        cattr_t   c;
        logic     d;
        logic     v;
    } tlb_hit_t;

    typedef enum logic [1:0] {
        TLBR  = 2'd0,
        TLBWI = 2'd1,
        TLBWR = 2'd2,
        TLBP  = 2'd3
    } tlb_op_e;

    typedef enum logic [1:0] {
        IDLE = 2'd0,
        EXEC = 2'd1,
        ACK  = 2'd2
    } cmd_state_e;

endpackage

`default_nettype wire

/* common/tlb_port_if.sv */
`default_nettype none

interface tlb_port_if import mmu_pkg::*; #(
    parameter int TLB_ENTRIES = 16,
    localparam int IDX_W = $clog2(TLB_ENTRIES)
) ();

    // write port
    logic             we;
    logic [IDX_W-1:0] w_index;
    tlb_entry_t       w_entry;

    // read port, answered combinationally
    logic [IDX_W-1:0] r_index;
    tlb_entry_t       r_entry;

    // probe search
    entry_hi_t        probe_hi;
    tlb_hit_t         probe_hit;

    modport ctrl (
        output we, w_index, w_entry, r_index, probe_hi,
        input  r_entry, probe_hit
    );

    modport array (
        input  we, w_index, w_entry, r_index, probe_hi,
        output r_entry, probe_hit
    );

endinterface

`default_nettype wire

/* tlb/tlb_match.sv */
`default_nettype none

module tlb_match import mmu_pkg::*; #(
    parameter int TLB_ENTRIES = 16,
    localparam int IDX_W = $clog2(TLB_ENTRIES)
) (
    input  tlb_entry_t i_entries [TLB_ENTRIES],
    input  vpn2_t      i_vpn2,
    input  asid_t      i_asid,
    input  logic       i_odd_page,
    output tlb_hit_t   o_hit
);

    logic [TLB_ENTRIES-1:0] match;
    logic [IDX_W-1:0]       sel;
    tlb_entry_t             entry;

    // every entry compared in parallel
    always_comb begin
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            match[i] = (i_entries[i].vpn2 == i_vpn2) &&
                       (i_entries[i].g || (i_entries[i].asid == i_asid));
        end
    end

    // scan from the top, lowest match is left last
    always_comb begin
        sel = '0;
        for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
            if (match[i]) begin
                sel = IDX_W'(i);
            end
        end
    end

    assign entry = i_entries[sel];

    always_comb begin
        o_hit = '0;
        if (|match) begin
            o_hit.found = 1'b1;
            o_hit.index = tlb_idx_t'(sel);
            if (i_odd_page) begin
                o_hit.pfn = entry.pfn1;
                o_hit.c   = entry.c1;
                o_hit.d   = entry.d1;
                o_hit.v   = entry.v1;
            end else begin
                o_hit.pfn = entry.pfn0;
                o_hit.c   = entry.c0;
                o_hit.d   = entry.d0;
                o_hit.v   = entry.v0;
            end
        end
    end

endmodule

`default_nettype wire

/* tlb/tlb_array.sv */
`default_nettype none

module tlb_array import mmu_pkg::*; #(
    parameter int TLB_ENTRIES = 16
) (
    input  logic       clk,
    input  logic       i_arst_n,
    input  asid_t      i_asid,
    input  vaddr_t     i_i_vaddr,
    input  vaddr_t     i_d_vaddr,
    tlb_port_if.array  tlb,
    output tlb_hit_t   o_i_hit,
    output tlb_hit_t   o_d_hit
);

    tlb_entry_t entries [TLB_ENTRIES];

    // cleared entries have V and G low
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < TLB_ENTRIES; i++) begin
                entries[i] <= '0;
            end
        end else if (tlb.we) begin
            entries[tlb.w_index] <= tlb.w_entry;
        end
    end

    assign tlb.r_entry = entries[tlb.r_index];

    // instruction fetch lookup
    tlb_match #(
        .TLB_ENTRIES (TLB_ENTRIES)
    ) u_i_match (
        .i_entries  (entries),
        .i_vpn2     (i_i_vaddr[31:13]),
        .i_asid     (i_asid),
        .i_odd_page (i_i_vaddr[12]),
        .o_hit      (o_i_hit)
    );

    // data lookup
    tlb_match #(
        .TLB_ENTRIES (TLB_ENTRIES)
    ) u_d_match (
        .i_entries  (entries),
        .i_vpn2     (i_d_vaddr[31:13]),
        .i_asid     (i_asid),
        .i_odd_page (i_d_vaddr[12]),
        .o_hit      (o_d_hit)
    );

    // TLBP only needs found and index
    tlb_match #(
        .TLB_ENTRIES (TLB_ENTRIES)
    ) u_p_match (
        .i_entries  (entries),
        .i_vpn2     (tlb.probe_hi[31:13]),
        .i_asid     (tlb.probe_hi[7:0]),
        .i_odd_page (1'b0),
        .o_hit      (tlb.probe_hit)
    );

endmodule

`default_nettype wire

/* verilog/tlb_cmd_ctrl.sv */
`default_nettype none

module tlb_cmd_ctrl import mmu_pkg::*; #(
    parameter int TLB_ENTRIES = 16,
    localparam int IDX_W = $clog2(TLB_ENTRIES)
) (
    input  logic             clk,
    input  logic             i_arst_n,
    input  logic             i_cmd_req,
    input  tlb_op_e          i_cmd_op,
    input  logic [IDX_W-1:0] i_cmd_index,
    input  entry_hi_t        i_cmd_entry_hi,
    input  entry_lo_t        i_cmd_entry_lo0,
    input  entry_lo_t        i_cmd_entry_lo1,
    output logic             o_cmd_ack,
    output logic             o_cmd_probe_miss,
    output logic [IDX_W-1:0] o_cmd_index,
    output entry_hi_t        o_cmd_entry_hi,
    output entry_lo_t        o_cmd_entry_lo0,
    output entry_lo_t        o_cmd_entry_lo1,
    tlb_port_if.ctrl         tlb
);

    cmd_state_e       state;
    logic [IDX_W-1:0] random_q;
    tlb_entry_t       r_entry;

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:    if (i_cmd_req) state <= EXEC;
                EXEC:    state <= ACK;
                // held while the core keeps req high
                ACK:     if (!i_cmd_req) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    assign o_cmd_ack = (state == ACK);

    // free-running Random, wraps to the top entry
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            random_q <= IDX_W'(TLB_ENTRIES - 1);
        end else if (random_q == '0) begin
            random_q <= IDX_W'(TLB_ENTRIES - 1);
        end else begin
            random_q <= random_q - 1'b1;
        end
    end

    // unpack EntryHi/EntryLo for writes
    assign tlb.we      = (state == EXEC) && (i_cmd_op == TLBWI || i_cmd_op == TLBWR);
    assign tlb.w_index = (i_cmd_op == TLBWR) ? random_q : i_cmd_index;
    always_comb begin
        tlb.w_entry      = '0;
        tlb.w_entry.vpn2 = i_cmd_entry_hi[31:13];
        tlb.w_entry.asid = i_cmd_entry_hi[7:0];
        tlb.w_entry.g    = i_cmd_entry_lo0[0] & i_cmd_entry_lo1[0];
        tlb.w_entry.pfn0 = i_cmd_entry_lo0[25:6];
        tlb.w_entry.c0   = i_cmd_entry_lo0[5:3];
        tlb.w_entry.d0   = i_cmd_entry_lo0[2];
        tlb.w_entry.v0   = i_cmd_entry_lo0[1];
        tlb.w_entry.pfn1 = i_cmd_entry_lo1[25:6];
        tlb.w_entry.c1   = i_cmd_entry_lo1[5:3];
        tlb.w_entry.d1   = i_cmd_entry_lo1[2];
        tlb.w_entry.v1   = i_cmd_entry_lo1[1];
    end

    assign tlb.r_index  = i_cmd_index;
    assign tlb.probe_hi = i_cmd_entry_hi;
    assign r_entry      = tlb.r_entry;

    // results change only for TLBR and TLBP
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_cmd_probe_miss <= 1'b0;
            o_cmd_index      <= '0;
            o_cmd_entry_hi   <= '0;
            o_cmd_entry_lo0  <= '0;
            o_cmd_entry_lo1  <= '0;
        end else if (state == EXEC) begin
            if (i_cmd_op == TLBR) begin
                o_cmd_entry_hi  <= {r_entry.vpn2, 5'b0, r_entry.asid};
                o_cmd_entry_lo0 <= {r_entry.pfn0, r_entry.c0, r_entry.d0, r_entry.v0, r_entry.g};
                o_cmd_entry_lo1 <= {r_entry.pfn1, r_entry.c1, r_entry.d1, r_entry.v1, r_entry.g};
            end else if (i_cmd_op == TLBP) begin
                o_cmd_probe_miss <= ~tlb.probe_hit.found;
                o_cmd_index      <= tlb.probe_hit.found ? tlb.probe_hit.index[IDX_W-1:0] : '0;
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/addr_xlate.sv */
`default_nettype none

module addr_xlate import mmu_pkg::*; (
    input  logic     i_valid,
    input  vaddr_t   i_vaddr,
    input  logic     i_write,
    input  cattr_t   i_config_k0,
    input  tlb_hit_t i_hit,
    output paddr_t   o_paddr,
    output logic     o_uncached,
    output logic     o_refill,
    output logic     o_invalid,
    output logic     o_modified
);

    logic mapped;
    logic in_kseg0;
    logic in_kseg1;
    logic hit_ok;

    // kuseg, kseg2 and kseg3 go through the TLB
    assign mapped   = ~i_vaddr[31] | (i_vaddr[31:30] == 2'b11);
    assign in_kseg0 = (i_vaddr[31:29] == 3'b100);
    assign in_kseg1 = (i_vaddr[31:29] == 3'b101);

    always_comb begin
        if (!mapped) begin
            o_paddr = {3'b000, i_vaddr[28:0]};
        end else if (i_hit.found) begin
            o_paddr = {i_hit.pfn, i_vaddr[11:0]};
        end else begin
            o_paddr = '0;
        end
    end

    assign o_uncached = in_kseg1
                      | (in_kseg0 & (i_config_k0 != CACHE_CACHEABLE))
                      | (mapped & (i_hit.c != CACHE_CACHEABLE));

    // valid, mapped and found
    assign hit_ok = i_valid & mapped & i_hit.found;

    assign o_refill   = i_valid & mapped & ~i_hit.found;
    assign o_invalid  = hit_ok & ~i_hit.v;
    // store to a clean page
    assign o_modified = hit_ok & i_hit.v & ~i_hit.d & i_write;

endmodule

`default_nettype wire

/* verilog/mmu_top.sv */
`default_nettype none

module mmu_top import mmu_pkg::*; #(
    parameter int TLB_ENTRIES = 16,
    localparam int IDX_W = $clog2(TLB_ENTRIES)
) (
    input  logic             clk,
    input  logic             i_arst_n,
    input  asid_t            i_asid,
    input  cattr_t           i_config_k0,

    input  logic             i_i_valid,
    input  vaddr_t           i_i_vaddr,
    output paddr_t           o_i_paddr,
    output logic             o_i_uncached,
    output logic             o_i_refill,
    output logic             o_i_invalid,

    input  logic             i_d_valid,
    input  vaddr_t           i_d_vaddr,
    input  logic             i_d_write,
    output paddr_t           o_d_paddr,
    output logic             o_d_uncached,
    output logic             o_d_refill,
    output logic             o_d_invalid,
    output logic             o_d_modified,

    input  logic             i_cmd_req,
    input  tlb_op_e          i_cmd_op,
    input  logic [IDX_W-1:0] i_cmd_index,
    input  entry_hi_t        i_cmd_entry_hi,
    input  entry_lo_t        i_cmd_entry_lo0,
    input  entry_lo_t        i_cmd_entry_lo1,
    output logic             o_cmd_ack,
    output logic             o_cmd_probe_miss,
    output logic [IDX_W-1:0] o_cmd_index,
    output entry_hi_t        o_cmd_entry_hi,
    output entry_lo_t        o_cmd_entry_lo0,
    output entry_lo_t        o_cmd_entry_lo1
);

    tlb_hit_t i_hit;
    tlb_hit_t d_hit;

    tlb_port_if #(.TLB_ENTRIES(TLB_ENTRIES)) tlb_if ();

    tlb_cmd_ctrl #(
        .TLB_ENTRIES (TLB_ENTRIES)
    ) u_cmd_ctrl (
        .clk,
        .i_arst_n,
        .i_cmd_req,
        .i_cmd_op,
        .i_cmd_index,
        .i_cmd_entry_hi,
        .i_cmd_entry_lo0,
        .i_cmd_entry_lo1,
        .o_cmd_ack,
        .o_cmd_probe_miss,
        .o_cmd_index,
        .o_cmd_entry_hi,
        .o_cmd_entry_lo0,
        .o_cmd_entry_lo1,
        .tlb             (tlb_if.ctrl)
    );

    tlb_array #(
        .TLB_ENTRIES (TLB_ENTRIES)
    ) u_tlb (
        .clk,
        .i_arst_n,
        .i_asid,
        .i_i_vaddr,
        .i_d_vaddr,
        .tlb       (tlb_if.array),
        .o_i_hit   (i_hit),
        .o_d_hit   (d_hit)
    );

    // fetches never write
    addr_xlate u_i_xlate (
        .i_valid     (i_i_valid),
        .i_vaddr     (i_i_vaddr),
        .i_write     (1'b0),
        .i_config_k0,
        .i_hit       (i_hit),
        .o_paddr     (o_i_paddr),
        .o_uncached  (o_i_uncached),
        .o_refill    (o_i_refill),
        .o_invalid   (o_i_invalid),
        .o_modified  ()
    );

    addr_xlate u_d_xlate (
        .i_valid     (i_d_valid),
        .i_vaddr     (i_d_vaddr),
        .i_write     (i_d_write),
        .i_config_k0,
        .i_hit       (d_hit),
        .o_paddr     (o_d_paddr),
        .o_uncached  (o_d_uncached),
        .o_refill    (o_d_refill),
        .o_invalid   (o_d_invalid),
        .o_modified  (o_d_modified)
    );

endmodule

`default_nettype wire

/* dv/tb_mmu_model.svh */
`ifndef TB_MMU_MODEL_SVH
`define TB_MMU_MODEL_SVH

// shadow TLB, kept in the form that TLBR returns
entry_hi_t shadow_hi  [TLB_ENTRIES];
entry_lo_t shadow_lo0 [TLB_ENTRIES];
entry_lo_t shadow_lo1 [TLB_ENTRIES];

task automatic model_write(input int idx, input entry_hi_t hi,
                           input entry_lo_t lo0, input entry_lo_t lo1);
    logic g;
    g = lo0[0] & lo1[0];
    // reserved EntryHi bits 12..8 read zero
    shadow_hi[idx]  = hi & 32'hffff_e0ff;
    shadow_lo0[idx] = {lo0[25:1], g};
    shadow_lo1[idx] = {lo1[25:1], g};
endtask

// lowest matching index, -1 when nothing matches
function automatic int model_search(input vpn2_t vpn2, input asid_t asid);
    for (int i = 0; i < TLB_ENTRIES; i++) begin
        if (shadow_hi[i][31:13] == vpn2 &&
            (shadow_lo0[i][0] || shadow_hi[i][7:0] == asid)) begin
            return i;
        end
    end
    return -1;
endfunction

// returns {paddr, uncached, refill, invalid, modified}
function automatic logic [35:0] model_xlate(input logic valid, input vaddr_t va,
                                            input logic wr, input asid_t asid,
                                            input cattr_t k0);
    int        idx;
    entry_lo_t lo;
    paddr_t    pa;
    logic      unc;
    logic      mapped;
    mapped = !va[31] || (va[31:30] == 2'b11);
    idx    = model_search(va[31:13], asid);
    lo     = '0;
    if (idx >= 0) begin
        lo = va[12] ? shadow_lo1[idx] : shadow_lo0[idx];
    end
    if (!mapped) begin
        // kseg1 has bit 29 set
        return {3'b000, va[28:0], va[29] || (k0 != 3'd3), 3'b000};
    end
    // a miss carries no C and reads as uncached
    pa  = (idx >= 0) ? {lo[25:6], va[11:0]} : '0;
    unc = (lo[5:3] != 3'd3);
    return {pa, unc, valid && idx < 0, valid && idx >= 0 && !lo[1],
            valid && idx >= 0 && lo[1] && !lo[2] && wr};
endfunction

`endif

/* dv/tb_mmu.sv */
`default_nettype none

module tb_mmu import mmu_pkg::*; ();

    localparam int TLB_ENTRIES = 16;
    localparam int IDX_W       = $clog2(TLB_ENTRIES);
    // roughly 2500 cycles of tests, with margin
    localparam int CYCLE_LIMIT = 6000;

    logic             clk             = 1'b0;
    logic             i_arst_n        = 1'b0;
    asid_t            i_asid          = '0;
    cattr_t           i_config_k0     = '0;
    logic             i_i_valid       = 1'b0;
    vaddr_t           i_i_vaddr       = '0;
    logic             i_d_valid       = 1'b0;
    vaddr_t           i_d_vaddr       = '0;
    logic             i_d_write       = 1'b0;
    logic             i_cmd_req       = 1'b0;
    tlb_op_e          i_cmd_op        = TLBR;
    logic [IDX_W-1:0] i_cmd_index     = '0;
    entry_hi_t        i_cmd_entry_hi  = '0;
    entry_lo_t        i_cmd_entry_lo0 = '0;
    entry_lo_t        i_cmd_entry_lo1 = '0;

    paddr_t           o_i_paddr;
    logic             o_i_uncached;
    logic             o_i_refill;
    logic             o_i_invalid;
    paddr_t           o_d_paddr;
    logic             o_d_uncached;
    logic             o_d_refill;
    logic             o_d_invalid;
    logic             o_d_modified;
    logic             o_cmd_ack;
    logic             o_cmd_probe_miss;
    logic [IDX_W-1:0] o_cmd_index;
    entry_hi_t        o_cmd_entry_hi;
    entry_lo_t        o_cmd_entry_lo0;
    entry_lo_t        o_cmd_entry_lo1;

    logic             xlate_en  = 1'b0;
    logic [31:0]      rng_state = 32'h149c_2597;
    int               cycles    = 0;
    logic             cmd_start;

    `include "tb_mmu_model.svh"

    mmu_top #(.TLB_ENTRIES(TLB_ENTRIES)) uut (.*);

    always #10 clk = ~clk;

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            fail_run($sformatf("timeout, run still going after %0d cycles", cycles));
        end
    end

    // req seen high while no ack is up
    assign cmd_start = i_cmd_req && !o_cmd_ack;

    // checks sit on the falling edge where everything is settled
    assert property (@(negedge clk) !i_arst_n |-> !o_cmd_ack && o_cmd_index == '0 &&
                     !o_cmd_probe_miss && o_cmd_entry_hi == '0 &&
                     o_cmd_entry_lo0 == '0 && o_cmd_entry_lo1 == '0)
        else fail_run($sformatf(
            "mismatch reset outputs exp 0 got ack %h miss %h index %h hi %h lo0 %h lo1 %h",
            o_cmd_ack, o_cmd_probe_miss, o_cmd_index, o_cmd_entry_hi,
            o_cmd_entry_lo0, o_cmd_entry_lo1));

    assert property (@(negedge clk) disable iff (!i_arst_n)
                     $past(cmd_start, 2) && !$past(cmd_start, 3) |-> o_cmd_ack)
        else fail_run($sformatf("mismatch o_cmd_ack 2 cycles after req exp 1 got %h",
                                o_cmd_ack));

    assert property (@(negedge clk) disable iff (!i_arst_n)
                     $rose(o_cmd_ack) |-> $past(cmd_start, 1) && $past(cmd_start, 2))
        else fail_run("ack rose without a request two cycles earlier");

    assert property (@(negedge clk) disable iff (!i_arst_n)
                     $past(o_cmd_ack && i_cmd_req) |-> o_cmd_ack)
        else fail_run("ack dropped while req was still high");

    assert property (@(negedge clk) disable iff (!i_arst_n) xlate_en |->
                     {o_i_paddr, o_i_uncached, o_i_refill, o_i_invalid, 1'b0} ==
                     model_xlate(i_i_valid, i_i_vaddr, 1'b0, i_asid, i_config_k0))
        else fail_run($sformatf("mismatch o_i_paddr/flags va %h exp %h got %h", i_i_vaddr,
                      model_xlate(i_i_valid, i_i_vaddr, 1'b0, i_asid, i_config_k0),
                      {o_i_paddr, o_i_uncached, o_i_refill, o_i_invalid, 1'b0}));

    assert property (@(negedge clk) disable iff (!i_arst_n) xlate_en |->
                     {o_d_paddr, o_d_uncached, o_d_refill, o_d_invalid, o_d_modified} ==
                     model_xlate(i_d_valid, i_d_vaddr, i_d_write, i_asid, i_config_k0))
        else fail_run($sformatf("mismatch o_d_paddr/flags va %h exp %h got %h", i_d_vaddr,
                      model_xlate(i_d_valid, i_d_vaddr, i_d_write, i_asid, i_config_k0),
                      {o_d_paddr, o_d_uncached, o_d_refill, o_d_invalid, o_d_modified}));

    function automatic logic [31:0] rand32();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // eight page pairs shared by writes and lookups, so entries collide
    function automatic vpn2_t pool_vpn2(input logic [2:0] k);
        return {k[2] ? 2'b11 : 2'b00, 15'h0, k[1:0]};
    endfunction

    function automatic vaddr_t rand_vaddr();
        logic [31:0] r;
        r = rand32();
        case (r[31:30])
            2'd0:    return {2'b10, r[29:0]};
            2'd3:    return rand32();
            default: return {pool_vpn2(r[2:0]), r[12:0]};
        endcase
    endfunction

    // reserved bits random on purpose
    function automatic entry_hi_t rand_hi();
        logic [31:0] r;
        r = rand32();
        return {pool_vpn2(r[2:0]), r[7:3], 6'b0, r[9:8]};
    endfunction

    function automatic entry_lo_t rand_lo();
        logic [31:0] r;
        r = rand32();
        if (r[31]) begin
            r[5:3] = 3'd3;
        end
        // mostly valid, so hits go on to the D check
        if (r[30]) begin
            r[1] = 1'b1;
        end
        return r[25:0];
    endfunction

    task automatic xlate_steps(input int n);
        logic [31:0] r;
        for (int s = 0; s < n; s++) begin
            r = rand32();
            @(posedge clk);
            xlate_en    <= 1'b1;
            i_asid      <= asid_t'(r[1:0]);
            i_config_k0 <= r[4:2];
            i_i_valid   <= (r[6:5] != 2'b00);
            i_d_valid   <= (r[8:7] != 2'b00);
            i_d_write   <= r[9];
            i_i_vaddr   <= rand_vaddr();
            i_d_vaddr   <= rand_vaddr();
        end
        @(posedge clk);
        xlate_en <= 1'b0;
    endtask

    // four-phase handshake, operands held until the next command
    task automatic run_cmd(input tlb_op_e op, input logic [IDX_W-1:0] idx,
                           input entry_hi_t hi, input entry_lo_t lo0, input entry_lo_t lo1);
        @(posedge clk);
        i_cmd_op        <= op;
        i_cmd_index     <= idx;
        i_cmd_entry_hi  <= hi;
        i_cmd_entry_lo0 <= lo0;
        i_cmd_entry_lo1 <= lo1;
        i_cmd_req       <= 1'b1;
        do @(negedge clk); while (!o_cmd_ack);
        @(posedge clk);
        i_cmd_req <= 1'b0;
        do @(negedge clk); while (o_cmd_ack);
    endtask

    task automatic read_check(input logic [IDX_W-1:0] idx);
        run_cmd(TLBR, idx, '0, '0, '0);
        assert (o_cmd_entry_hi == shadow_hi[idx])
            else fail_run($sformatf("mismatch o_cmd_entry_hi exp %h got %h",
                                    shadow_hi[idx], o_cmd_entry_hi));
        assert (o_cmd_entry_lo0 == shadow_lo0[idx])
            else fail_run($sformatf("mismatch o_cmd_entry_lo0 exp %h got %h",
                                    shadow_lo0[idx], o_cmd_entry_lo0));
        assert (o_cmd_entry_lo1 == shadow_lo1[idx])
            else fail_run($sformatf("mismatch o_cmd_entry_lo1 exp %h got %h",
                                    shadow_lo1[idx], o_cmd_entry_lo1));
    endtask

    task automatic write_and_read(input logic [IDX_W-1:0] idx);
        entry_hi_t hi;
        entry_lo_t lo0;
        entry_lo_t lo1;
        hi  = rand_hi();
        lo0 = rand_lo();
        lo1 = rand_lo();
        run_cmd(TLBWI, idx, hi, lo0, lo1);
        model_write(idx, hi, lo0, lo1);
        read_check(idx);
    endtask

    task automatic probe_check(input entry_hi_t hi);
        int               exp_idx;
        logic [IDX_W-1:0] exp_index;
        exp_idx   = model_search(hi[31:13], hi[7:0]);
        exp_index = (exp_idx < 0) ? '0 : IDX_W'(exp_idx);
        run_cmd(TLBP, '0, hi, '0, '0);
        assert (o_cmd_probe_miss == (exp_idx < 0))
            else fail_run($sformatf("mismatch o_cmd_probe_miss hi %h exp %h got %h",
                                    hi, exp_idx < 0, o_cmd_probe_miss));
        assert (o_cmd_index == exp_index)
            else fail_run($sformatf("mismatch o_cmd_index hi %h exp %h got %h",
                                    hi, exp_index, o_cmd_index));
    endtask

    task automatic random_write_check(input int n);
        entry_hi_t   hi;
        entry_lo_t   lo0;
        entry_lo_t   lo1;
        logic [31:0] r;
        r   = rand32();
        // a VPN2 outside the lookup pool, new on every call
        hi  = {2'b01, 9'h0, 8'(n), 5'b0, r[7:0]};
        lo0 = rand_lo();
        lo1 = rand_lo();
        run_cmd(TLBWR, '0, hi, lo0, lo1);
        run_cmd(TLBP, '0, hi, '0, '0);
        assert (!o_cmd_probe_miss)
            else fail_run("TLBP missed the entry that TLBWR just wrote");
        model_write(o_cmd_index, hi, lo0, lo1);
        read_check(o_cmd_index);
    endtask

    initial begin
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            model_write(i, '0, '0, '0);
        end
        repeat (2) @(posedge clk);
        i_arst_n <= 1'b1;
        // unmapped segments, then the all-zero TLB
        xlate_steps(300);
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            write_and_read(IDX_W'(i));
        end
        for (int i = 0; i < 24; i++) begin
            write_and_read(IDX_W'(rand32()));
        end
        xlate_steps(600);
        for (int p = 0; p < 40; p++) begin
            entry_hi_t hi;
            hi = rand_hi();
            // every fourth probe leaves the pool and misses
            if (p % 4 == 3) begin
                hi[29] = 1'b1;
            end
            probe_check(hi);
        end
        for (int n = 0; n < 8; n++) begin
            random_write_check(n);
        end
        xlate_steps(600);
        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* mmu_lite.f */
+incdir+dv
common/mmu_pkg.sv
common/tlb_port_if.sv
tlb/tlb_match.sv
tlb/tlb_array.sv
verilog/tlb_cmd_ctrl.sv
verilog/addr_xlate.sv
verilog/mmu_top.sv
dv/tb_mmu.sv

/* run_sim.sh */
#!/bin/sh
# build the MMU testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_mmu -f mmu_lite.f \
    --Mdir obj_dir -o tb_mmu_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/tb_mmu_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation failed with status $status"
    exit "$status"
fi

exit 0
